/* sim/rv32i_testdata.txt */
# records: T test_name | I program_word (hex, placed from the reset pc upward)
# C expected commit: order pc rd rd_value (all hex, in program order)
T upper_imm
I 123450B7
I 00001117
C 0 100 1 12345000
C 1 104 2 00001104
T alu_fwd
I FFF08193
I 40118233
I FFF0C293
I 4082D313
I 0082D393
I 4022D433
I 00309493
I 0022F533
I 0F016593
I 00730633
C 2 108 3 12344FFF
C 3 10C 4 FFFFFFFF
C 4 110 5 EDCBAFFF
C 5 114 6 FFEDCBAF
C 6 118 7 00EDCBAF
C 7 11C 8 FEDCBAFF
C 8 120 9 91A28000
C 9 124 a 00000104
C a 128 b 000011F4
C b 12C c 00DB975E
T compare
I 0012A6B3
I 0012B733
I FFF32793
I FFF3B813
C c 130 d 00000001
C d 134 e 00000000
C e 138 f 00000001
C f 13C 10 00000001
T x0_writes
I ABCDE037
I 07F00893
C 10 140 0 00000000
C 11 144 11 0000007F

/* tb.f */
verilog/rv32i_types.sv
verilog/fetch_stage.sv
verilog/id_stage.sv
verilog/regfile.sv
verilog/ex_stage.sv
verilog/wb_stage.sv
verilog/rv32i_core.sv
sim/commit_checker.sv
sim/tb_rv32i_core.sv

/* sim/tb_rv32i_core.sv */
`timescale 1ns/1ps

module tb_rv32i_core;

    localparam logic [31:0] reset_pc  = 32'h0000_0100;
    localparam int          max_words = 64;
    localparam logic [31:0] nop_word  = 32'h0000_0013; // addi x0, x0, 0.

    logic        clk          = 1'b0;
    logic        i_arst_n     = 1'b0;
    logic        i_imem_resp  = 1'b0;
    logic [31:0] i_imem_rdata = 32'h0000_0000;
    logic        o_imem_req;
    logic [31:0] o_imem_addr;
    logic        o_commit_valid;
    logic [63:0] o_commit_order;
    logic [31:0] o_commit_pc;
    logic [31:0] o_commit_inst;
    logic [4:0]  o_commit_rd;
    logic [31:0] o_commit_rd_v;

    logic [31:0] prog [0:max_words-1];
    int          n_words    = 0;
    int          wait_left  = 0;
    logic [31:0] serve_addr = reset_pc;
    integer      seed       = 32'h5ea6_5a80;
    logic        file_error = 1'b0;
    logic        chk_done;
    logic [31:0] chk_errors;

    always #4 clk = ~clk;

    rv32i_core #(
        .P_RESET_PC (reset_pc)
    ) dut_i (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .o_imem_req     (o_imem_req),
        .o_imem_addr    (o_imem_addr),
        .i_imem_resp    (i_imem_resp),
        .i_imem_rdata   (i_imem_rdata),
        .o_commit_valid (o_commit_valid),
        .o_commit_order (o_commit_order),
        .o_commit_pc    (o_commit_pc),
        .o_commit_inst  (o_commit_inst),
        .o_commit_rd    (o_commit_rd),
        .o_commit_rd_v  (o_commit_rd_v)
    );

    commit_checker #(
        .P_RESET_PC (reset_pc)
    ) commit_checker_i (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_imem_req     (o_imem_req),
        .i_imem_addr    (o_imem_addr),
        .i_imem_resp    (i_imem_resp),
        .i_commit_valid (o_commit_valid),
        .i_commit_order (o_commit_order),
        .i_commit_pc    (o_commit_pc),
        .i_commit_inst  (o_commit_inst),
        .i_commit_rd    (o_commit_rd),
        .i_commit_rd_v  (o_commit_rd_v),
        .o_done         (chk_done),
        .o_error_count  (chk_errors)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction memory model.
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        int idx;
        idx = (addr - reset_pc) >> 2;
        if (addr >= reset_pc && idx < n_words) begin
            return prog[idx];
        end
        return nop_word; // past the end of the program.
    endfunction

    // each request is answered after 0 to 3 idle cycles.
    always @(posedge clk) begin
        if (!i_arst_n) begin
            i_imem_resp <= 1'b0;
            wait_left   = {$random(seed)} % 4;
        end else if (wait_left == 0) begin
            i_imem_resp  <= 1'b1;
            i_imem_rdata <= fetch_word(serve_addr);
            serve_addr   = serve_addr + 32'd4; // fetch moves on after a response.
            wait_left    = {$random(seed)} % 4;
        end else begin
            i_imem_resp <= 1'b0;
            wait_left   = wait_left - 1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // testdata loading, reset and run control.
    initial begin : main_seq
        int               fd;
        int               code;
        int               limit;
        int               cycles;
        logic [255:0]     tok;
        logic [255:0]     name;
        logic [8*128-1:0] line;
        logic [31:0]      word;
        logic [63:0]      ord;
        logic [31:0]      pc;
        logic [31:0]      rd;
        logic [31:0]      rd_v;

        fd = $fopen("sim/rv32i_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the testdata file sim/rv32i_testdata.txt");
            file_error = 1'b1;
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok == "#") begin
                    code = $fgets(line, fd);
                end else if (tok == "T") begin
                    code = $fscanf(fd, "%s", name);
                    commit_checker_i.add_test(name);
                end else if (tok == "I") begin
                    code = $fscanf(fd, "%h", word);
                    prog[n_words] = word;
                    n_words++;
                    commit_checker_i.add_word(word);
                end else if (tok == "C") begin
                    code = $fscanf(fd, "%h %h %h %h", ord, pc, rd, rd_v);
                    commit_checker_i.add_expect(ord, pc, rd[4:0], rd_v);
                end else begin
                    $display("unknown record kind %0s in the testdata file", tok);
                    file_error = 1'b1;
                end
            end
            $fclose(fd);
        end

        repeat (5) @(posedge clk);
        i_arst_n <= 1'b1;

        limit  = n_words * 5 + 3 + 50; // worst latency per word, pipeline depth, margin.
        cycles = 0;
        while (!chk_done && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end

        commit_checker_i.report_counts();
        if (!chk_done) begin
            $display("timeout after %0d cycles, the commits stopped short of the expected list",
                     cycles);
        end
        if (chk_done && chk_errors == 0 && !file_error) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* sim/commit_checker.sv */
`timescale 1ns/1ps

module commit_checker #(
    parameter logic [31:0] P_RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        i_arst_n,
    input  logic        i_imem_req,
    input  logic [31:0] i_imem_addr,
    input  logic        i_imem_resp,
    input  logic        i_commit_valid,
    input  logic [63:0] i_commit_order,
    input  logic [31:0] i_commit_pc,
    input  logic [31:0] i_commit_inst,
    input  logic [4:0]  i_commit_rd,
    input  logic [31:0] i_commit_rd_v,
    output logic        o_done,
    output logic [31:0] o_error_count
);

    localparam int max_tests = 16;
    localparam int max_recs  = 64;

    logic [255:0] test_name [0:max_tests-1];
    int           test_errs [0:max_tests-1];
    int           rec_test  [0:max_recs-1]; // owning test of each record.
    logic [63:0]  exp_order [0:max_recs-1];
    logic [31:0]  exp_pc    [0:max_recs-1];
    logic [4:0]   exp_rd    [0:max_recs-1];
    logic [31:0]  exp_rd_v  [0:max_recs-1];
    logic [31:0]  prog_word [0:max_recs-1];
    logic [31:0]  fetch_addr = P_RESET_PC;
    int           n_tests  = 0;
    int           n_recs   = 0;
    int           n_words  = 0;
    int           n_seen   = 0;
    int           n_passed = 0;
    int           errors   = 0;

    assign o_done        = (n_recs > 0) && (n_seen == n_recs);
    assign o_error_count = errors;

    task automatic add_test(input logic [255:0] name);
        test_name[n_tests] = name;
        test_errs[n_tests] = 0;
        n_tests++;
    endtask

    task automatic add_word(input logic [31:0] word);
        prog_word[n_words] = word;
        n_words++;
    endtask

    task automatic add_expect(input logic [63:0] order, input logic [31:0] pc,
                              input logic [4:0] rd, input logic [31:0] rd_v);
        rec_test[n_recs]  = n_tests - 1;
        exp_order[n_recs] = order;
        exp_pc[n_recs]    = pc;
        exp_rd[n_recs]    = rd;
        exp_rd_v[n_recs]  = rd_v;
        n_recs++;
    endtask

    // program word stored at a given pc.
    function automatic logic [31:0] word_at(input logic [31:0] pc);
        return prog_word[(pc - P_RESET_PC) >> 2];
    endfunction

    task automatic compare(input string sig, input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            $display("ERROR %0s: expected 0x%0h, got 0x%0h at commit %0d", sig, exp, act, n_seen);
            errors++;
            test_errs[rec_test[n_seen]]++;
        end
    endtask

    task automatic report_test(input int t);
        if (test_errs[t] == 0) begin
            $display("test %0s: pass", test_name[t]);
            n_passed++;
        end else begin
            $display("test %0s: FAIL with %0d mismatches", test_name[t], test_errs[t]);
        end
    endtask

    task automatic report_counts();
        $display("summary: %0d of %0d tests passed, %0d of %0d commits seen, %0d errors",
                 n_passed, n_tests, n_seen, n_recs, errors);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // commits are compared in order, extra ones past the list are ignored.
    always @(negedge clk) begin
        // each response answers the next word address.
        if (i_arst_n && i_imem_resp) begin
            if (i_imem_req !== 1'b1) begin
                $display("ERROR o_imem_req: expected 0x1, got 0x%0h", i_imem_req);
                errors++;
            end
            if (i_imem_addr !== fetch_addr) begin
                $display("ERROR o_imem_addr: expected 0x%0h, got 0x%0h",
                         fetch_addr, i_imem_addr);
                errors++;
            end
            fetch_addr = fetch_addr + 32'd4;
        end
        if (i_arst_n && i_commit_valid && n_seen < n_recs) begin
            compare("o_commit_order", exp_order[n_seen], i_commit_order);
            compare("o_commit_pc", exp_pc[n_seen], i_commit_pc);
            compare("o_commit_inst", word_at(exp_pc[n_seen]), i_commit_inst);
            compare("o_commit_rd", exp_rd[n_seen], i_commit_rd);
            compare("o_commit_rd_v", exp_rd_v[n_seen], i_commit_rd_v);
            if (n_seen == n_recs - 1 || rec_test[n_seen + 1] != rec_test[n_seen]) begin
                report_test(rec_test[n_seen]);
            end
            n_seen++;
        end
    end

endmodule

/* verilog/rv32i_core.sv */
`timescale 1ns/1ps

module rv32i_core
    import rv32i_types::*;
#(
    parameter logic [31:0] P_RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        i_arst_n,
    output logic        o_imem_req,
    output logic [31:0] o_imem_addr,
    input  logic        i_imem_resp,
    input  logic [31:0] i_imem_rdata,
    output logic        o_commit_valid,
    output logic [63:0] o_commit_order,
    output logic [31:0] o_commit_pc,
    output logic [31:0] o_commit_inst,
    output logic [4:0]  o_commit_rd,
    output logic [31:0] o_commit_rd_v
);

    if_id_stage_reg_t if_id;
    id_ex_stage_reg_t id_ex;
    ex_wb_stage_reg_t ex_wb;
    regf_wr_t         regf_wr;
    logic [4:0]       rs1_s;
    logic [4:0]       rs2_s;
    logic [31:0]      rs1_v;
    logic [31:0]      rs2_v;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fetch, decode, execute, writeback.
    fetch_stage #(
        .P_RESET_PC (P_RESET_PC)
    ) fetch_stage_i (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_imem_resp (i_imem_resp),
        .o_imem_req  (o_imem_req),
        .o_imem_addr (o_imem_addr),
        .o_if_id     (if_id)
    );

    id_stage id_stage_i (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_if_id      (if_id),
        .i_imem_resp  (i_imem_resp),
        .i_imem_rdata (i_imem_rdata),
        .i_rs1_v      (rs1_v),
        .i_rs2_v      (rs2_v),
        .o_rs1_s      (rs1_s),
        .o_rs2_s      (rs2_s),
        .o_id_ex      (id_ex)
    );

    regfile regfile_i (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_wr     (regf_wr),
        .i_rs1_s  (rs1_s),
        .i_rs2_s  (rs2_s),
        .o_rs1_v  (rs1_v),
        .o_rs2_v  (rs2_v)
    );

    ex_stage ex_stage_i (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_id_ex  (id_ex),
        .i_wb_fwd (regf_wr),
        .o_ex_wb  (ex_wb)
    );

    wb_stage wb_stage_i (
        .i_ex_wb        (ex_wb),
        .o_regf_wr      (regf_wr),
        .o_commit_valid (o_commit_valid),
        .o_commit_order (o_commit_order),
        .o_commit_pc    (o_commit_pc),
        .o_commit_inst  (o_commit_inst),
        .o_commit_rd    (o_commit_rd),
        .o_commit_rd_v  (o_commit_rd_v)
    );

endmodule

/* verilog/wb_stage.sv */
`timescale 1ns/1ps

module wb_stage
    import rv32i_types::*;
(
    input  ex_wb_stage_reg_t i_ex_wb,
    output regf_wr_t         o_regf_wr,
    output logic             o_commit_valid,
    output logic [63:0]      o_commit_order,
    output logic [31:0]      o_commit_pc,
    output logic [31:0]      o_commit_inst,
    output logic [4:0]       o_commit_rd,
    output logic [31:0]      o_commit_rd_v
);

    logic [31:0] rd_v;
    logic        we;

    always_comb begin
        case (i_ex_wb.wb_signal.regf_m_sel)
            br_en_wb: rd_v = {31'd0, i_ex_wb.br_en};
            u_imm_wb: rd_v = i_ex_wb.u_imm;
            default:  rd_v = i_ex_wb.alu_out;
        endcase
    end

    // writes to x0 are dropped here, downstream logic relies on it.
    assign we = i_ex_wb.valid && i_ex_wb.wb_signal.regf_we && (i_ex_wb.rd_s != 5'd0);

    assign o_regf_wr = '{we: we, rd_s: i_ex_wb.rd_s, rd_v: rd_v};

    assign o_commit_valid = i_ex_wb.valid;
    assign o_commit_order = i_ex_wb.order;
    assign o_commit_pc    = i_ex_wb.pc;
    assign o_commit_inst  = i_ex_wb.inst;
    assign o_commit_rd    = we ? i_ex_wb.rd_s : 5'd0;
    assign o_commit_rd_v  = we ? rd_v : 32'd0;

endmodule

/* verilog/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage
    import rv32i_types::*;
(
    input  logic             clk,
    input  logic             i_arst_n,
    input  id_ex_stage_reg_t i_id_ex,
    input  regf_wr_t         i_wb_fwd,
    output ex_wb_stage_reg_t o_ex_wb
);

    logic [31:0]      rs1_v;
    logic [31:0]      rs2_v;
    logic [31:0]      alu_a;
    logic [31:0]      alu_b;
    logic [31:0]      cmp_b;
    logic [31:0]      alu_out;
    logic             br_en;
    ex_wb_stage_reg_t ex_wb_d;

    // wb to ex forwarding, we is already clear for x0.
    assign rs1_v = (i_wb_fwd.we && i_wb_fwd.rd_s == i_id_ex.rs1_s) ? i_wb_fwd.rd_v
                                                                   : i_id_ex.rs1_v;
    assign rs2_v = (i_wb_fwd.we && i_wb_fwd.rd_s == i_id_ex.rs2_s) ? i_wb_fwd.rd_v
                                                                   : i_id_ex.rs2_v;

    always_comb begin
        alu_a = (i_id_ex.ex_signal.alu_m1_sel == pc_out_alu_ex) ? i_id_ex.pc : rs1_v;
        case (i_id_ex.ex_signal.alu_m2_sel)
            i_imm_alu_ex: alu_b = i_id_ex.i_imm;
            u_imm_alu_ex: alu_b = i_id_ex.u_imm;
            default:      alu_b = rs2_v;
        endcase
        cmp_b = (i_id_ex.ex_signal.cmp_m_sel == i_imm_cmp_ex) ? i_id_ex.i_imm : rs2_v;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // alu and comparator.
    always_comb begin
        case (i_id_ex.ex_signal.alu_ops)
            add_alu_op:  alu_out = alu_a + alu_b;
            sub_alu_op:  alu_out = alu_a - alu_b;
            sll_alu_op:  alu_out = alu_a << alu_b[4:0];
            xor_alu_op:  alu_out = alu_a ^ alu_b;
            srl_alu_op:  alu_out = alu_a >> alu_b[4:0];
            sra_alu_op:  alu_out = $unsigned($signed(alu_a) >>> alu_b[4:0]);
            or_alu_op:   alu_out = alu_a | alu_b;
            and_alu_op:  alu_out = alu_a & alu_b;
            default:     alu_out = '0;
        endcase

        case (i_id_ex.ex_signal.cmp_ops)
            bltu_cmp_op: br_en = rs1_v < cmp_b;
            default:     br_en = $signed(rs1_v) < $signed(cmp_b);
        endcase
    end

    always_comb begin
        ex_wb_d.valid     = i_id_ex.valid;
        ex_wb_d.inst      = i_id_ex.inst;
        ex_wb_d.pc        = i_id_ex.pc;
        ex_wb_d.order     = i_id_ex.order;
        ex_wb_d.rd_s      = i_id_ex.rd_s;
        ex_wb_d.wb_signal = i_id_ex.wb_signal;
        ex_wb_d.alu_out   = alu_out;
        ex_wb_d.br_en     = br_en;
        ex_wb_d.u_imm     = i_id_ex.u_imm;
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) o_ex_wb <= '0;
        else           o_ex_wb <= ex_wb_d;
    end

endmodule

/* verilog/regfile.sv */
`timescale 1ns/1ps

module regfile
    import rv32i_types::*;
(
    input  logic        clk,
    input  logic        i_arst_n,
    input  regf_wr_t    i_wr,
    input  logic [4:0]  i_rs1_s,
    input  logic [4:0]  i_rs2_s,
    output logic [31:0] o_rs1_v,
    output logic [31:0] o_rs2_v
);

    logic [31:0] regs [1:31]; // x0 has no storage.

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr.we) begin
            regs[i_wr.rd_s] <= i_wr.rd_v;
        end
    end

    // write-through covers a producer in wb and a consumer in id.
    always_comb begin
        if (i_rs1_s == 5'd0)                     o_rs1_v = '0;
        else if (i_wr.we && i_wr.rd_s == i_rs1_s) o_rs1_v = i_wr.rd_v;
        else                                     o_rs1_v = regs[i_rs1_s];

        if (i_rs2_s == 5'd0)                     o_rs2_v = '0;
        else if (i_wr.we && i_wr.rd_s == i_rs2_s) o_rs2_v = i_wr.rd_v;
        else                                     o_rs2_v = regs[i_rs2_s];
    end

endmodule

/* verilog/id_stage.sv */
`timescale 1ns/1ps

module id_stage
    import rv32i_types::*;
(
    input  logic             clk,
    input  logic             i_arst_n,
    input  if_id_stage_reg_t i_if_id,
    input  logic             i_imem_resp,
    input  logic [31:0]      i_imem_rdata,
    input  logic [31:0]      i_rs1_v,
    input  logic [31:0]      i_rs2_v,
    output logic [4:0]       o_rs1_s,
    output logic [4:0]       o_rs2_s,
    output id_ex_stage_reg_t o_id_ex
);

    rv32i_inst_u      inst;
    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [31:0]      i_imm;
    logic [31:0]      u_imm;
    ex_signal_t       ex_signal;
    wb_signal_t       wb_signal;
    id_ex_stage_reg_t id_ex_d;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // field extraction.
    assign inst    = i_imem_rdata;
    assign opcode  = inst.r_fmt.opcode;
    assign funct3  = inst.i_fmt.funct3;
    assign funct7  = inst.r_fmt.funct7;
    assign i_imm   = {{20{inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};
    assign u_imm   = {inst.u_fmt.imm20, 12'h000};
    assign o_rs1_s = inst.r_fmt.rs1;
    assign o_rs2_s = inst.r_fmt.rs2; // overlaps imm12 on I-type, harmless.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control generation.
    always_comb begin
        ex_signal.alu_m1_sel = rs1_v_alu_ex;
        ex_signal.alu_m2_sel = rs2_v_alu_ex;
        ex_signal.alu_ops    = add_alu_op;
        ex_signal.cmp_m_sel  = rs2_v_cmp_ex;
        ex_signal.cmp_ops    = blt_cmp_op;
        wb_signal.regf_m_sel = alu_out_wb;
        wb_signal.regf_we    = 1'b0; // unknown opcodes retire as no-ops.

        case (opcode)
            lui_opcode: begin
                wb_signal.regf_m_sel = u_imm_wb;
                wb_signal.regf_we    = 1'b1;
            end
            auipc_opcode: begin
                ex_signal.alu_m1_sel = pc_out_alu_ex;
                ex_signal.alu_m2_sel = u_imm_alu_ex;
                wb_signal.regf_we    = 1'b1;
            end
            imm_opcode, reg_opcode: begin
                wb_signal.regf_we = 1'b1;
                if (opcode == imm_opcode) begin
                    ex_signal.alu_m2_sel = i_imm_alu_ex;
                    ex_signal.cmp_m_sel  = i_imm_cmp_ex;
                end
                case (funct3)
                    slt_funct3: begin
                        ex_signal.cmp_ops    = blt_cmp_op;
                        wb_signal.regf_m_sel = br_en_wb;
                    end
                    sltu_funct3: begin
                        ex_signal.cmp_ops    = bltu_cmp_op;
                        wb_signal.regf_m_sel = br_en_wb;
                    end
                    sr_funct3: begin
                        ex_signal.alu_ops = funct7[5] ? sra_alu_op : srl_alu_op;
                    end
                    add_funct3: begin
                        // addi has no subtract form.
                        if (opcode == reg_opcode && funct7[5]) begin
                            ex_signal.alu_ops = sub_alu_op;
                        end else begin
                            ex_signal.alu_ops = add_alu_op;
                        end
                    end
                    default: begin
                        ex_signal.alu_ops = alu_op_t'({1'b0, funct3});
                    end
                endcase
            end
            default: begin
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // id/ex register.
    always_comb begin
        id_ex_d.valid     = i_imem_resp & i_if_id.valid;
        id_ex_d.inst      = i_imem_rdata;
        id_ex_d.pc        = i_if_id.pc;
        id_ex_d.order     = i_if_id.order;
        id_ex_d.ex_signal = ex_signal;
        id_ex_d.wb_signal = wb_signal;
        id_ex_d.i_imm     = i_imm;
        id_ex_d.u_imm     = u_imm;
        id_ex_d.rs1_s     = o_rs1_s;
        id_ex_d.rs2_s     = o_rs2_s;
        id_ex_d.rd_s      = inst.u_fmt.rd;
        id_ex_d.rs1_v     = i_rs1_v;
        id_ex_d.rs2_v     = i_rs2_v;
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_id_ex <= '0;
        end else begin
            o_id_ex <= id_ex_d;
        end
    end

endmodule

/* verilog/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage
    import rv32i_types::*;
#(
    parameter logic [31:0] P_RESET_PC = 32'h0000_0000
) (
    input  logic             clk,
    input  logic             i_arst_n,
    input  logic             i_imem_resp,
    output logic             o_imem_req,
    output logic [31:0]      o_imem_addr,
    output if_id_stage_reg_t o_if_id
);

    logic [31:0] pc_q;
    logic [63:0] order_q;

    // pc and order move on only when the memory has answered.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q    <= P_RESET_PC;
            order_q <= '0;
        end else if (i_imem_resp) begin
            pc_q    <= pc_q + 32'd4;
            order_q <= order_q + 64'd1;
        end
    end

    // a request is always open, memory latency is the only stall.
    assign o_imem_req  = 1'b1;
    assign o_imem_addr = pc_q;

    always_comb begin
        o_if_id.valid = o_imem_req; // tags the outstanding request.
        o_if_id.pc    = pc_q;
        o_if_id.order = order_q;
    end

endmodule

/* verilog/rv32i_types.sv */
package rv32i_types;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // opcodes and funct3 codes.
    localparam logic [6:0] lui_opcode   = 7'b0110111;
    localparam logic [6:0] auipc_opcode = 7'b0010111;
    localparam logic [6:0] imm_opcode   = 7'b0010011;
    localparam logic [6:0] reg_opcode   = 7'b0110011;

    localparam logic [2:0] add_funct3  = 3'b000;
    localparam logic [2:0] sll_funct3  = 3'b001;
    localparam logic [2:0] slt_funct3  = 3'b010;
    localparam logic [2:0] sltu_funct3 = 3'b011;
    localparam logic [2:0] xor_funct3  = 3'b100;
    localparam logic [2:0] sr_funct3   = 3'b101;
    localparam logic [2:0] or_funct3   = 3'b110;
    localparam logic [2:0] and_funct3  = 3'b111;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // low three bits follow funct3, bit 3 marks sub and sra.
    typedef enum logic [3:0] {
        add_alu_op  = 4'b0000,
        sll_alu_op  = 4'b0001,
        slt_alu_op  = 4'b0010,
        sltu_alu_op = 4'b0011,
        xor_alu_op  = 4'b0100,
        srl_alu_op  = 4'b0101,
        or_alu_op   = 4'b0110,
        and_alu_op  = 4'b0111,
        sub_alu_op  = 4'b1000,
        sra_alu_op  = 4'b1101
    } alu_op_t;

    typedef enum logic [2:0] {
        blt_cmp_op  = 3'b100,
        bltu_cmp_op = 3'b110
    } cmp_op_t;

    typedef enum logic {rs1_v_alu_ex, pc_out_alu_ex} alu_m1_sel_t;
    typedef enum logic [1:0] {rs2_v_alu_ex, i_imm_alu_ex, u_imm_alu_ex} alu_m2_sel_t;
    typedef enum logic {rs2_v_cmp_ex, i_imm_cmp_ex} cmp_m_sel_t;
    typedef enum logic [1:0] {alu_out_wb, br_en_wb, u_imm_wb} regf_m_sel_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction word formats.
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        u_fmt_t u_fmt;
    } rv32i_inst_u;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control bundles and stage registers.
    typedef struct packed {
        alu_m1_sel_t alu_m1_sel;
        alu_m2_sel_t alu_m2_sel;
        alu_op_t     alu_ops;
        cmp_m_sel_t  cmp_m_sel;
        cmp_op_t     cmp_ops;
    } ex_signal_t;

    typedef struct packed {
        regf_m_sel_t regf_m_sel;
        logic        regf_we;
    } wb_signal_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [63:0] order;
    } if_id_stage_reg_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] inst;
        logic [31:0] pc;
        logic [63:0] order;
        ex_signal_t  ex_signal;
        wb_signal_t  wb_signal;
        logic [31:0] i_imm;
        logic [31:0] u_imm;
        logic [4:0]  rs1_s;
        logic [4:0]  rs2_s;
        logic [4:0]  rd_s;
        logic [31:0] rs1_v;
        logic [31:0] rs2_v;
    } id_ex_stage_reg_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] inst;
        logic [31:0] pc;
        logic [63:0] order;
        logic [4:0]  rd_s;
        wb_signal_t  wb_signal;
        logic [31:0] alu_out;
        logic        br_en;
        logic [31:0] u_imm;
    } ex_wb_stage_reg_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  rd_s;
        logic [31:0] rd_v;
    } regf_wr_t;

endpackage
